/* compile.f */
+incdir+.
emifBusPkg.sv
shellCtrlPkg.sv
emifDecoder.sv
mmioRegFile.sv
xmemDpram.sv
mmioClient.sv
mmioClient_asserts.sv
tb_mmioClient.sv

/* emifBusPkg.sv */
// PSoC bus types: address, data byte, page offset and page number
`include "mmioClient_settings.svh"
`default_nettype none

package emifBusPkg;

  typedef logic [`EMIF_AW-1:0] emifAddrT;   // Full bus address
  typedef logic [`EMIF_DW-1:0] emifDataT;   // One bus byte
  typedef logic [`PAGE_AW-1:0] regOffsetT;  // Offset inside a page

  // Low bits of PAGE_SEL, 16 pages of 128 bytes
  typedef logic [$clog2(`XMEM_BYTES)-`PAGE_AW-1:0] pageNumT;

endpackage

`default_nettype wire

/* emifDecoder.sv */
// PSoC bus decoder: register/memory enables and read data steering
`timescale 1ns/1ps
`default_nettype none

module emifDecoder (
  input  wire logic                 shlClk,
  input  wire logic                 arstN,
  input  wire logic                 emifCsN,
  input  wire emifBusPkg::emifAddrT emifAddr,
  output logic                      regEn,
  output logic                      memEn,
  input  wire emifBusPkg::emifDataT regRdData,
  input  wire emifBusPkg::emifDataT memRdData,
  output emifBusPkg::emifDataT      emifRdData
);

  localparam int cWinBit = $bits(emifBusPkg::emifAddrT) - 1;  // Upper half is the window

  logic selMem;  // Target of the last access

  //----------------------------------------
  // Target select
  //----------------------------------------
  assign regEn = !emifCsN && !emifAddr[cWinBit];  // Lower 128 bytes
  assign memEn = !emifCsN && emifAddr[cWinBit];   // Paged memory window

  // Targets return data one cycle after the access
  always_ff @(posedge shlClk or negedge arstN)
  begin
    if (!arstN)
      selMem <= 1'b0;                  // Register path reads 0x00 after reset
    else if (!emifCsN)
      selMem <= emifAddr[cWinBit];
  end

  assign emifRdData = selMem ? memRdData : regRdData;

endmodule

`default_nettype wire

/* mmioClient.sv */
// MMIO client top: bus decoder, register file and exchange memory
`include "mmioClient_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mmioClient (
  input  wire logic                   shlClk,
  input  wire logic                   arstN,
  // PSoC bus
  input  wire logic                   emifCsN,
  input  wire logic                   emifWeN,
  input  wire emifBusPkg::emifAddrT   emifAddr,
  input  wire emifBusPkg::emifDataT   emifWrData,
  output emifBusPkg::emifDataT        emifRdData,
  // Status
  input  wire logic                   mc0InitCalComplete,
  input  wire logic                   mc1InitCalComplete,
  input  wire logic                   eth0CoreReady,
  input  wire logic                   eth0QpllLock,
  // Transceiver controls
  output logic                        eth0RxEqualizerMode,
  output shellCtrlPkg::txSwingT       eth0TxDriverSwing,
  output shellCtrlPkg::txCursorT      eth0TxPreCursor,
  output shellCtrlPkg::txCursorT      eth0TxPostCursor,
  output logic                        eth0PcsLoopbackEn,
  output logic                        eth0MacLoopbackEn,
  output logic                        eth0MacAddrSwapEn,
  // Network stack settings
  output shellCtrlPkg::macAddrT       nts0MacAddress,
  output shellCtrlPkg::ipv4AddrT      nts0IpAddress,
  output shellCtrlPkg::ipv4AddrT      nts0SubNetMask,
  output shellCtrlPkg::ipv4AddrT      nts0GatewayAddr,
  // Role test controls
  output shellCtrlPkg::echoCtrlT      roleUdpEchoCtrl,
  output shellCtrlPkg::echoCtrlT      roleTcpEchoCtrl,
  output logic                        roleUdpPostPktEn,
  output logic                        roleUdpCaptPktEn,
  output logic                        roleTcpPostPktEn,
  output logic                        roleTcpCaptPktEn,
  // Fabric side of the exchange memory
  input  wire logic                   xmemEn,
  input  wire logic                   xmemWrEn,
  input  wire logic [`XMEM_WAW-1:0]   xmemAddr,
  input  wire shellCtrlPkg::xmemWordT xmemWrData,
  output shellCtrlPkg::xmemWordT      xmemRdData
);

  logic                 regEn;
  logic                 memEn;
  emifBusPkg::emifDataT regRdData;
  emifBusPkg::emifDataT memRdData;
  emifBusPkg::pageNumT  pageNum;     // From PAGE_SEL

  //----------------------------------------
  // Bus decode
  //----------------------------------------
  emifDecoder decoder (
    .shlClk     (shlClk),
    .arstN      (arstN),
    .emifCsN    (emifCsN),
    .emifAddr   (emifAddr),
    .regEn      (regEn),
    .memEn      (memEn),
    .regRdData  (regRdData),
    .memRdData  (memRdData),
    .emifRdData (emifRdData)
  );

  // Lower page
  mmioRegFile regFile (
    .shlClk              (shlClk),
    .arstN               (arstN),
    .regEn               (regEn),
    .emifWeN             (emifWeN),
    .regOffset           (emifAddr[`PAGE_AW-1:0]),
    .wrData              (emifWrData),
    .regRdData           (regRdData),
    .pageNum             (pageNum),
    .mc0InitCalComplete  (mc0InitCalComplete),
    .mc1InitCalComplete  (mc1InitCalComplete),
    .eth0CoreReady       (eth0CoreReady),
    .eth0QpllLock        (eth0QpllLock),
    .eth0RxEqualizerMode (eth0RxEqualizerMode),
    .eth0TxDriverSwing   (eth0TxDriverSwing),
    .eth0TxPreCursor     (eth0TxPreCursor),
    .eth0TxPostCursor    (eth0TxPostCursor),
    .eth0PcsLoopbackEn   (eth0PcsLoopbackEn),
    .eth0MacLoopbackEn   (eth0MacLoopbackEn),
    .eth0MacAddrSwapEn   (eth0MacAddrSwapEn),
    .nts0MacAddress      (nts0MacAddress),
    .nts0IpAddress       (nts0IpAddress),
    .nts0SubNetMask      (nts0SubNetMask),
    .nts0GatewayAddr     (nts0GatewayAddr),
    .roleUdpEchoCtrl     (roleUdpEchoCtrl),
    .roleTcpEchoCtrl     (roleTcpEchoCtrl),
    .roleUdpPostPktEn    (roleUdpPostPktEn),
    .roleUdpCaptPktEn    (roleUdpCaptPktEn),
    .roleTcpPostPktEn    (roleTcpPostPktEn),
    .roleTcpCaptPktEn    (roleTcpCaptPktEn)
  );

  // Upper page window
  xmemDpram xmem (
    .shlClk     (shlClk),
    .memEn      (memEn),
    .emifWeN    (emifWeN),
    .pageNum    (pageNum),
    .regOffset  (emifAddr[`PAGE_AW-1:0]),
    .wrData     (emifWrData),
    .memRdData  (memRdData),
    .xmemEn     (xmemEn),
    .xmemWrEn   (xmemWrEn),
    .xmemAddr   (xmemAddr),
    .xmemWrData (xmemWrData),
    .xmemRdData (xmemRdData)
  );

endmodule

`default_nettype wire

/* mmioClient_asserts.sv */
// Bound checks on bus read data, control output stability and reset values
`include "mmioClient_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mmioClient_asserts #(
  parameter int cCtrlW = 170  // All eth0, nts0 and role outputs
) (
  input wire logic                   shlClk,
  input wire logic                   arstN,
  input wire logic                   emifCsN,
  input wire logic                   emifWeN,
  input wire emifBusPkg::emifDataT   emifRdData,
  input wire shellCtrlPkg::ipv4AddrT nts0SubNetMask,
  input wire logic [cCtrlW-1:0]      ctrlState
);

  // Bytes 0x3B down to 0x38
  localparam shellCtrlPkg::ipv4AddrT cSnmReset = {8'h00, 8'h00, 8'hFF, 8'hFF};

  int failCount = 0;  // Read by the testbench verdict

  //----------------------------------------
  // Bus side
  //----------------------------------------
  rdKnown: assert property (@(posedge shlClk) disable iff (!arstN)
    (!emifCsN && emifWeN) |=> !$isunknown(emifRdData))
    else
    begin
      $error("emifRdData unknown one cycle after a read");
      failCount++;
    end

  // Controls only move on a bus write
  ctrlHeld: assert property (@(posedge shlClk) disable iff (!arstN)
    emifCsN |=> $stable(ctrlState))
    else
    begin
      $error("Control output changed without a bus access");
      failCount++;
    end

  snmReset: assert property (@(posedge shlClk)
    !arstN |-> nts0SubNetMask == cSnmReset)
    else
    begin
      $error("nts0SubNetMask not at its default during reset");
      failCount++;
    end

endmodule

`default_nettype wire

/* mmioClient_settings.svh */
// Bus and memory geometry, register offsets, identification and reset values
`ifndef MMIO_CLIENT_SETTINGS_SVH
`define MMIO_CLIENT_SETTINGS_SVH

//----------------------------------------
// Geometry
//----------------------------------------
`define EMIF_AW     8     // PSoC address bus
`define EMIF_DW     8     // PSoC data bus
`define PAGE_AW     7     // Offset inside a 128-byte page
`define XMEM_BYTES  2048  // Exchange memory size
`define XMEM_WW     32    // Fabric word
`define XMEM_WAW    9     // Fabric word address

// Identification and build stamp (flash/super build)
`define EMIF_ID      8'h3D
`define EMIF_VER     8'h01
`define EMIF_REV     8'h00
`define CFG_RSVD_VAL 8'h33
`define TOP_ID       8'h01
`define TOP_YEAR     8'hFF  // Stamped at build time
`define TOP_MONTH    8'hFF
`define TOP_DAY      8'hFF

//----------------------------------------
// Register offsets in the lower page
//----------------------------------------
`define CFG_EMIF_ID   7'h00
`define CFG_EMIF_VER  7'h01
`define CFG_EMIF_REV  7'h02
`define CFG_RSVD      7'h03
`define CFG_TOP_ID    7'h04
`define CFG_TOP_YEAR  7'h05
`define CFG_TOP_MONTH 7'h06
`define CFG_TOP_DAY   7'h07
`define PHY_STAT      7'h10   // Status inputs, read only
`define PHY_ETH0      7'h11   // Three tuning bytes
`define LY2_MAC       7'h22   // Six bytes
`define LY3_IP        7'h34
`define LY3_SNM       7'h38
`define LY3_GTW       7'h3C
`define DIAG_SCRATCH  7'h70
`define DIAG_CTRL_1   7'h74   // Loopback controls
`define DIAG_CTRL_2   7'h76   // Role test controls
`define PAGE_SEL      7'h7F

// Reset values with the lowest address in the low byte
`define PHY_ETH0_DEF     24'h05_05_41
`define LY2_MAC_DEF      48'h0
`define LY3_IP_DEF       32'h0
`define LY3_SNM_DEF      32'h0000_FFFF  // 255.255.0.0
`define LY3_GTW_DEF      32'h0100_020A  // 10.2.0.1
`define DIAG_SCRATCH_DEF 32'hEFBE_ADDE
`define DIAG_CTRL_1_DEF  8'h00
`define DIAG_CTRL_2_DEF  8'h00
`define PAGE_SEL_DEF     8'h00

`endif

/* mmioRegFile.sv */
// Register map: identification, status, tuning, network, diagnostic and page registers
`include "mmioClient_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mmioRegFile (
  input  wire logic                  shlClk,
  input  wire logic                  arstN,
  input  wire logic                  regEn,
  input  wire logic                  emifWeN,
  input  wire emifBusPkg::regOffsetT regOffset,
  input  wire emifBusPkg::emifDataT  wrData,
  output emifBusPkg::emifDataT       regRdData,
  output emifBusPkg::pageNumT        pageNum,
  // Status
  input  wire logic                  mc0InitCalComplete,
  input  wire logic                  mc1InitCalComplete,
  input  wire logic                  eth0CoreReady,
  input  wire logic                  eth0QpllLock,
  // Transceiver
  output logic                       eth0RxEqualizerMode,
  output shellCtrlPkg::txSwingT      eth0TxDriverSwing,
  output shellCtrlPkg::txCursorT     eth0TxPreCursor,
  output shellCtrlPkg::txCursorT     eth0TxPostCursor,
  output logic                       eth0PcsLoopbackEn,
  output logic                       eth0MacLoopbackEn,
  output logic                       eth0MacAddrSwapEn,
  // Network stack
  output shellCtrlPkg::macAddrT      nts0MacAddress,
  output shellCtrlPkg::ipv4AddrT     nts0IpAddress,
  output shellCtrlPkg::ipv4AddrT     nts0SubNetMask,
  output shellCtrlPkg::ipv4AddrT     nts0GatewayAddr,
  // Role tests
  output shellCtrlPkg::echoCtrlT     roleUdpEchoCtrl,
  output shellCtrlPkg::echoCtrlT     roleTcpEchoCtrl,
  output logic                       roleUdpPostPktEn,
  output logic                       roleUdpCaptPktEn,
  output logic                       roleTcpPostPktEn,
  output logic                       roleTcpCaptPktEn
);

  //----------------------------------------
  // Storage slots of the read/write bytes
  //----------------------------------------
  localparam int cEthSlot  = 0;   // PHY_ETH0, 3 bytes
  localparam int cMacSlot  = 3;   // LY2_MAC, 6 bytes
  localparam int cIpSlot   = 9;
  localparam int cSnmSlot  = 13;
  localparam int cGtwSlot  = 17;
  localparam int cScrSlot  = 21;  // Scratch, no fabric output
  localparam int cCtl1Slot = 25;
  localparam int cCtl2Slot = 26;
  localparam int cPageSlot = 27;
  localparam int cRwBytes  = 28;
  localparam int cGroups   = 9;

  // Group base offsets and first slots, last entry closes the table
  localparam emifBusPkg::regOffsetT cBase [cGroups] = '{
    `PHY_ETH0, `LY2_MAC, `LY3_IP, `LY3_SNM, `LY3_GTW,
    `DIAG_SCRATCH, `DIAG_CTRL_1, `DIAG_CTRL_2, `PAGE_SEL
  };
  localparam int cFirst [cGroups+1] = '{
    cEthSlot, cMacSlot, cIpSlot, cSnmSlot, cGtwSlot,
    cScrSlot, cCtl1Slot, cCtl2Slot, cPageSlot, cRwBytes
  };

  localparam emifBusPkg::emifDataT [cRwBytes-1:0] cRwDef = {
    `PAGE_SEL_DEF, `DIAG_CTRL_2_DEF, `DIAG_CTRL_1_DEF, `DIAG_SCRATCH_DEF,
    `LY3_GTW_DEF, `LY3_SNM_DEF, `LY3_IP_DEF, `LY2_MAC_DEF, `PHY_ETH0_DEF
  };

  emifBusPkg::emifDataT [cRwBytes-1:0] rwReg;  // Implemented bytes only
  emifBusPkg::emifDataT                rdMux;
  logic [5:0]                          slot;   // {hit, index}

  // Offset to storage slot, bit 5 flags an implemented byte
  function automatic logic [5:0] slotOf(input emifBusPkg::regOffsetT off);
    logic [5:0] res;
    int         g;
    res = '0;
    for (g = 0; g < cGroups; g++)
    begin
      if (off >= cBase[g] && off < cBase[g] + cFirst[g+1] - cFirst[g])
        res = {1'b1, 5'(cFirst[g] + off - cBase[g])};
    end
    return res;
  endfunction

  assign slot = slotOf(regOffset);

  //----------------------------------------
  // Write path
  //----------------------------------------
  always_ff @(posedge shlClk or negedge arstN)
  begin
    if (!arstN)
      rwReg <= cRwDef;
    else if (regEn && !emifWeN && slot[5])   // RO and holes ignored
      rwReg[slot[4:0]] <= wrData;
  end

  //----------------------------------------
  // Read path
  //----------------------------------------
  always_comb
  begin
    rdMux = '0;  // Unimplemented reads as zero
    case (regOffset)
      `CFG_EMIF_ID:   rdMux = `EMIF_ID;
      `CFG_EMIF_VER:  rdMux = `EMIF_VER;
      `CFG_EMIF_REV:  rdMux = `EMIF_REV;
      `CFG_RSVD:      rdMux = `CFG_RSVD_VAL;
      `CFG_TOP_ID:    rdMux = `TOP_ID;
      `CFG_TOP_YEAR:  rdMux = `TOP_YEAR;
      `CFG_TOP_MONTH: rdMux = `TOP_MONTH;
      `CFG_TOP_DAY:   rdMux = `TOP_DAY;
      `PHY_STAT:      rdMux = {4'h0, eth0QpllLock, eth0CoreReady,
                               mc1InitCalComplete, mc0InitCalComplete};
      default:
      begin
        if (slot[5])
          rdMux = rwReg[slot[4:0]];
      end
    endcase
  end

  // Held until the next register read
  always_ff @(posedge shlClk or negedge arstN)
  begin
    if (!arstN)
      regRdData <= '0;
    else if (regEn && emifWeN)
      regRdData <= rdMux;  // Status sampled here
  end

  //----------------------------------------
  // Control fields
  //----------------------------------------
  assign eth0RxEqualizerMode = rwReg[cEthSlot][0];
  assign eth0TxDriverSwing   = rwReg[cEthSlot][7:4];
  assign eth0TxPreCursor     = rwReg[cEthSlot+1][4:0];
  assign eth0TxPostCursor    = rwReg[cEthSlot+2][4:0];

  // Lowest address lands in the low byte
  assign nts0MacAddress  = rwReg[cMacSlot+5:cMacSlot];
  assign nts0IpAddress   = rwReg[cIpSlot+3:cIpSlot];
  assign nts0SubNetMask  = rwReg[cSnmSlot+3:cSnmSlot];
  assign nts0GatewayAddr = rwReg[cGtwSlot+3:cGtwSlot];

  assign eth0PcsLoopbackEn = rwReg[cCtl1Slot][0];
  assign eth0MacLoopbackEn = rwReg[cCtl1Slot][1];
  assign eth0MacAddrSwapEn = rwReg[cCtl1Slot][2];

  assign roleUdpEchoCtrl  = rwReg[cCtl2Slot][1:0];
  assign roleUdpPostPktEn = rwReg[cCtl2Slot][2];
  assign roleUdpCaptPktEn = rwReg[cCtl2Slot][3];
  assign roleTcpEchoCtrl  = rwReg[cCtl2Slot][5:4];
  assign roleTcpPostPktEn = rwReg[cCtl2Slot][6];
  assign roleTcpCaptPktEn = rwReg[cCtl2Slot][7];

  assign pageNum = rwReg[cPageSlot][$bits(emifBusPkg::pageNumT)-1:0];  // Upper bits unused

endmodule

`default_nettype wire

/* shellCtrlPkg.sv */
// Shell-facing field types and the exchange-memory word union
`include "mmioClient_settings.svh"
`default_nettype none

package shellCtrlPkg;

  //----------------------------------------
  // Network stack settings
  //----------------------------------------
  typedef logic [47:0] macAddrT;
  typedef logic [31:0] ipv4AddrT;   // IP, subnet mask and gateway

  // Transceiver tuning
  typedef logic [3:0] txSwingT;
  typedef logic [4:0] txCursorT;    // Pre and post cursor

  typedef logic [1:0] echoCtrlT;    // Role echo mode

  //----------------------------------------
  // Exchange memory word
  //----------------------------------------
  typedef logic [`XMEM_WW-1:0] xmemWordT;

  // Fabric view and PSoC byte view of one stored word
  typedef union packed {
    xmemWordT word;
    emifBusPkg::emifDataT [`XMEM_WW/`EMIF_DW-1:0] lane;  // Lane 0 is bits 7:0
  } xmemWordU;

endpackage

`default_nettype wire

/* tb_mmioClient.sv */
// Testbench for the MMIO client: stimulus table, clock, reset, compare tasks, watchdog, verdict
`include "mmioClient_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_mmioClient;

  localparam int cPeriod = 40;

  typedef enum int {kBusWr, kBusRd, kFabWr, kFabRd} kindT;

  typedef struct {
    kindT        kind;
    int          addr;   // Bus address or fabric word
    logic [31:0] data;
    logic [31:0] exp;
    string       name;
  } entryT;

  entryT tbl[$];
  int    phaseEnd[5];               // Output checks after each phase
  int    seed = 32'hfe3d_525c;
  int    valueErrs = 0;
  bit    tableBuilt = 1'b0;

  shellCtrlPkg::macAddrT  macExp;    // Random MAC, lowest address in low byte
  shellCtrlPkg::ipv4AddrT ipExp;

  // DUT ports, connected by name
  logic                    shlClk, arstN, emifCsN, emifWeN;
  emifBusPkg::emifAddrT    emifAddr;
  emifBusPkg::emifDataT    emifWrData, emifRdData;
  logic                    mc0InitCalComplete, mc1InitCalComplete, eth0CoreReady, eth0QpllLock;
  logic                    eth0RxEqualizerMode, eth0PcsLoopbackEn, eth0MacLoopbackEn;
  logic                    eth0MacAddrSwapEn;
  shellCtrlPkg::txSwingT   eth0TxDriverSwing;
  shellCtrlPkg::txCursorT  eth0TxPreCursor, eth0TxPostCursor;
  shellCtrlPkg::macAddrT   nts0MacAddress;
  shellCtrlPkg::ipv4AddrT  nts0IpAddress, nts0SubNetMask, nts0GatewayAddr;
  shellCtrlPkg::echoCtrlT  roleUdpEchoCtrl, roleTcpEchoCtrl;
  logic                    roleUdpPostPktEn, roleUdpCaptPktEn, roleTcpPostPktEn, roleTcpCaptPktEn;
  logic                    xmemEn, xmemWrEn;
  logic [`XMEM_WAW-1:0]    xmemAddr;
  shellCtrlPkg::xmemWordT  xmemWrData, xmemRdData;

  mmioClient dut (.*);

  bind mmioClient mmioClient_asserts chk (
    .shlClk, .arstN, .emifCsN, .emifWeN, .emifRdData, .nts0SubNetMask,
    .ctrlState ({eth0RxEqualizerMode, eth0TxDriverSwing, eth0TxPreCursor, eth0TxPostCursor,
                 eth0PcsLoopbackEn, eth0MacLoopbackEn, eth0MacAddrSwapEn, nts0MacAddress,
                 nts0IpAddress, nts0SubNetMask, nts0GatewayAddr, roleUdpEchoCtrl,
                 roleTcpEchoCtrl, roleUdpPostPktEn, roleUdpCaptPktEn, roleTcpPostPktEn,
                 roleTcpCaptPktEn})
  );

  //----------------------------------------
  // Compare tasks
  //----------------------------------------
  task automatic flagError(input string name, input string exp, input string act);
    valueErrs++;
    $display("ERROR %s: expected %s, actual %s", name, exp, act);
  endtask

  task automatic compareByte(input string name, input emifBusPkg::emifDataT exp, act);
    if (act !== exp)
      flagError(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic compareWord(input string name, input shellCtrlPkg::xmemWordT exp, act);
    if (act !== exp)
      flagError(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic compareIpv4(input string name, input shellCtrlPkg::ipv4AddrT exp, act);
    if (act !== exp)
      flagError(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic compareMac(input string name, input shellCtrlPkg::macAddrT exp, act);
    if (act !== exp)
      flagError(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic compareCursor(input string name, input shellCtrlPkg::txCursorT exp, act);
    if (act !== exp)
      flagError(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  //----------------------------------------
  // Table building
  //----------------------------------------
  task automatic addEntry(input kindT kind, input int addr, input logic [31:0] data,
                          input logic [31:0] exp, input string name);
    tbl.push_back('{kind, addr, data, exp, name});
  endtask

  // Byte runs, byte i of the vector goes to base + i
  task automatic addWrites(input int base, input int n, input logic [63:0] bytes,
                           input string name);
    for (int i = 0; i < n; i++)
      addEntry(kBusWr, base + i, bytes[8*i +: 8], 0, name);
  endtask

  task automatic addReads(input int base, input int n, input logic [63:0] bytes,
                          input string name);
    for (int i = 0; i < n; i++)
      addEntry(kBusRd, base + i, 0, bytes[8*i +: 8], $sformatf("%s byte %0d", name, i));
  endtask

  task automatic buildTable();
    shellCtrlPkg::xmemWordT scrExp;
    shellCtrlPkg::xmemWordT fabWord;
    logic [63:0]            memBytes;
    // Reset defaults
    addReads(`CFG_EMIF_ID, 8, {`TOP_DAY, `TOP_MONTH, `TOP_YEAR, 8'h01, 8'h33, 8'h00, 8'h01,
                               8'h3D}, "cfg id");
    addReads(`PHY_STAT, 1, 8'h00, "phy stat idle");
    addReads(`PHY_ETH0, 3, {8'h05, 8'h05, 8'h41}, "phy eth0 reset");
    addReads(`LY3_SNM, 4, {8'h00, 8'h00, 8'hFF, 8'hFF}, "subnet reset");
    addReads(`LY3_GTW, 4, {8'h01, 8'h00, 8'h02, 8'h0A}, "gateway reset");
    addReads(`DIAG_SCRATCH, 4, {8'hEF, 8'hBE, 8'hAD, 8'hDE}, "scratch reset");
    phaseEnd[0] = tbl.size();
    // Random read/write bytes
    macExp = {16'($random(seed)), 32'($random(seed))};
    ipExp  = $random(seed);
    scrExp = $random(seed);
    addWrites(`LY2_MAC, 6, macExp, "mac");
    addWrites(`LY3_IP, 4, ipExp, "ip");
    addWrites(`DIAG_SCRATCH, 4, scrExp, "scratch");
    addReads(`LY2_MAC, 6, macExp, "mac");
    addReads(`LY3_IP, 4, ipExp, "ip");
    addReads(`DIAG_SCRATCH, 4, scrExp, "scratch");
    phaseEnd[1] = tbl.size();
    // Control fields
    addWrites(`PHY_ETH0, 3, {8'h2C, 8'hF3, 8'hA7}, "phy eth0");
    addWrites(`DIAG_CTRL_1, 1, 8'hFD, "diag ctrl 1");
    addWrites(`DIAG_CTRL_2, 1, 8'h9E, "diag ctrl 2");
    addReads(`PHY_ETH0, 3, {8'h2C, 8'hF3, 8'hA7}, "phy eth0");
    addReads(`DIAG_CTRL_1, 1, 8'hFD, "diag ctrl 1");
    addReads(`DIAG_CTRL_2, 1, 8'h9E, "diag ctrl 2");
    phaseEnd[2] = tbl.size();
    // Read-only bytes and holes, status inputs driven to 4'b1010
    addWrites(`CFG_EMIF_ID, 1, 8'h55, "ro id");
    addWrites(`PHY_STAT, 1, 8'hFF, "ro stat");
    addWrites(8'h50, 1, 8'h77, "hole");
    addReads(`CFG_EMIF_ID, 1, 8'h3D, "ro id");
    addReads(`PHY_STAT, 1, 8'h0A, "phy stat live");
    addReads(8'h50, 1, 8'h00, "hole");
    phaseEnd[3] = tbl.size();
    // Page 3 window, offset 0x10 is word 3*32 + 4
    memBytes = {$random(seed), $random(seed)};
    fabWord  = $random(seed);
    addWrites(`PAGE_SEL, 1, 8'h03, "page sel");
    addWrites(8'h90, 8, memBytes, "window");
    addEntry(kFabRd, 3*32 + 4, 0, memBytes[31:0], "fabric word 100");
    addEntry(kFabRd, 3*32 + 5, 0, memBytes[63:32], "fabric word 101");
    addEntry(kFabWr, 3*32 + 8, fabWord, 0, "fabric word 104");
    addReads(8'hA0, 4, fabWord, "window of word 104");
    addReads(`PAGE_SEL, 1, 8'h03, "page sel");
    phaseEnd[4] = tbl.size();
  endtask

  //----------------------------------------
  // Driving and output checks
  //----------------------------------------
  task automatic applyEntry(input entryT e);
    @(negedge shlClk);
    emifAddr   = e.addr[7:0];
    emifWrData = e.data[7:0];
    xmemAddr   = e.addr[`XMEM_WAW-1:0];
    xmemWrData = e.data;
    emifCsN    = !(e.kind == kBusWr || e.kind == kBusRd);
    emifWeN    = (e.kind != kBusWr);
    xmemEn     = (e.kind == kFabWr || e.kind == kFabRd);
    xmemWrEn   = (e.kind == kFabWr);
    @(negedge shlClk);
    emifCsN  = 1'b1;  // Back to idle
    emifWeN  = 1'b1;
    xmemEn   = 1'b0;
    xmemWrEn = 1'b0;
    if (e.kind == kBusRd)
      compareByte(e.name, e.exp[7:0], emifRdData);
    else if (e.kind == kFabRd)
      compareWord(e.name, e.exp, xmemRdData);
  endtask

  task automatic checkControls(input emifBusPkg::emifDataT tune, ctl1, ctl2,
                               input shellCtrlPkg::txCursorT pre, post);
    compareByte("eth0 swing and rx eq", tune,
                {eth0TxDriverSwing, 3'b000, eth0RxEqualizerMode});
    compareCursor("eth0 pre cursor", pre, eth0TxPreCursor);
    compareCursor("eth0 post cursor", post, eth0TxPostCursor);
    compareByte("diag ctrl 1 fields", ctl1,
                {5'b00000, eth0MacAddrSwapEn, eth0MacLoopbackEn, eth0PcsLoopbackEn});
    compareByte("diag ctrl 2 fields", ctl2,
                {roleTcpCaptPktEn, roleTcpPostPktEn, roleTcpEchoCtrl,
                 roleUdpCaptPktEn, roleUdpPostPktEn, roleUdpEchoCtrl});
  endtask

  task automatic checkPhase(input int ph);
    case (ph)
      0:
      begin
        checkControls(8'h41 & 8'hF1, 8'h00, 8'h00, 5'h05, 5'h05);
        compareMac("mac reset", '0, nts0MacAddress);
        compareIpv4("ip reset", '0, nts0IpAddress);
        compareIpv4("subnet reset", {8'h00, 8'h00, 8'hFF, 8'hFF}, nts0SubNetMask);
        compareIpv4("gateway reset", {8'h01, 8'h00, 8'h02, 8'h0A}, nts0GatewayAddr);
      end
      1:
      begin
        compareMac("mac assembled", macExp, nts0MacAddress);
        compareIpv4("ip assembled", ipExp, nts0IpAddress);
      end
      2: checkControls(8'hA7 & 8'hF1, 8'hFD & 8'h07, 8'h9E, 5'h13, 5'h0C);
      default: ;
    endcase
  endtask

  //----------------------------------------
  // Clock, sequence and watchdog
  //----------------------------------------
  initial
  begin
    shlClk = 1'b0;
    forever #(cPeriod/2) shlClk = ~shlClk;
  end

  initial
  begin
    int idx;
    arstN              = 1'b1;
    emifCsN            = 1'b1;
    emifWeN            = 1'b1;
    emifAddr           = '0;
    emifWrData         = '0;
    {mc0InitCalComplete, mc1InitCalComplete, eth0CoreReady, eth0QpllLock} = 4'b0000;
    xmemEn             = 1'b0;
    xmemWrEn           = 1'b0;
    xmemAddr           = '0;
    xmemWrData         = '0;
    buildTable();
    tableBuilt = 1'b1;
    #(cPeriod/8) arstN = 1'b0;
    repeat (5) @(negedge shlClk);
    compareByte("read data in reset", 8'h00, emifRdData);  // Cleared by reset
    arstN = 1'b1;
    idx = 0;
    for (int ph = 0; ph < 5; ph++)
    begin
      if (ph == 3)  // Status on bits 1 and 3
        {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = 4'b1010;
      while (idx < phaseEnd[ph])
      begin
        applyEntry(tbl[idx]);
        idx++;
      end
      checkPhase(ph);
    end
    $display("Errors: %0d value mismatches, %0d assertion failures over %0d table entries",
             valueErrs, dut.chk.failCount, tbl.size());
    if (valueErrs == 0 && dut.chk.failCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Four cycles per entry plus reset
  initial
  begin
    wait (tableBuilt);
    #((tbl.size() * 4 + 5 + 2) * cPeriod);
    $display("Timeout: the stimulus table did not finish in %0d cycles", tbl.size() * 4 + 7);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* xmemDpram.sv */
// Paged exchange memory with a PSoC byte port and a fabric word port
`include "mmioClient_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module xmemDpram (
  input  wire logic                  shlClk,
  // PSoC byte port
  input  wire logic                  memEn,
  input  wire logic                  emifWeN,
  input  wire emifBusPkg::pageNumT   pageNum,
  input  wire emifBusPkg::regOffsetT regOffset,
  input  wire emifBusPkg::emifDataT  wrData,
  output emifBusPkg::emifDataT       memRdData,
  // Fabric word port
  input  wire logic                  xmemEn,
  input  wire logic                  xmemWrEn,
  input  wire logic [`XMEM_WAW-1:0]  xmemAddr,
  input  wire shellCtrlPkg::xmemWordT xmemWrData,
  output shellCtrlPkg::xmemWordT     xmemRdData
);

  localparam int cLanes = `XMEM_WW / `EMIF_DW;
  localparam int cLaneW = $clog2(cLanes);
  localparam int cWords = `XMEM_BYTES / cLanes;  // 512

  shellCtrlPkg::xmemWordU mem [cWords];  // No reset

  logic [$clog2(`XMEM_BYTES)-1:0] byteAddr;
  logic [`XMEM_WAW-1:0]           psocWord;
  logic [cLaneW-1:0]              psocLane;
  logic                           psocWr;
  logic                           fabWr;

  //----------------------------------------
  // PSoC address split
  //----------------------------------------
  assign byteAddr = {pageNum, regOffset};     // Page joined to offset
  assign psocWord = byteAddr[$bits(byteAddr)-1:cLaneW];
  assign psocLane = byteAddr[cLaneW-1:0];

  // Fabric wins a same-word write
  assign fabWr  = xmemEn && xmemWrEn;
  assign psocWr = memEn && !emifWeN && !(fabWr && xmemAddr == psocWord);

  //----------------------------------------
  // Both ports, read before write
  //----------------------------------------
  always_ff @(posedge shlClk)
  begin
    if (psocWr)
      mem[psocWord].lane[psocLane] <= wrData;
    if (fabWr)
      mem[xmemAddr].word <= xmemWrData;
    if (memEn && emifWeN)
      memRdData <= mem[psocWord].lane[psocLane];  // Held until next read
    if (xmemEn)
      xmemRdData <= mem[xmemAddr].word;           // Old word on a write
  end

endmodule

`default_nettype wire
